// ==== Makefile ====
# Verilator build and run for the microinstruction control testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

SRCS := $(wildcard hw/*.sv hw/*.svh tb/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+hw
hw/isa_pkg.sv
hw/ctl_pkg.sv
hw/run_ctl.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/cpu_top.sv
tb/tb_cpu.sv

// ==== hw/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path width, one memory word
`define CPU_WORD_W 16

// word address, 4K words of memory
`define CPU_ADDR_W 12

// general registers r0..r7
`define CPU_NREG 8

`endif

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic           __clk,
	input  logic           rst,
	input  logic           start,
	input  logic           stop,
	input  isa_pkg::word_t mem_rdata,
	output logic           run,
	output logic           halted,
	output isa_pkg::addr_t mem_addr,
	output logic           mem_rd,
	output logic           mem_wr,
	output isa_pkg::word_t mem_wdata
);

	import isa_pkg::*;
	import ctl_pkg::*;

	logic       halt;
	logic       f_rd;
	addr_t      f_addr;
	logic       mem_grant;
	logic       ir_valid;
	word_t      ir;
	word_t      f_arg;
	logic       stall;
	logic       d_valid;
	uop_t       uop;
	reg_idx_t   ra;
	reg_idx_t   rc;
	logic [3:0] shift_cnt;
	word_t      d_arg;
	logic       busy;
	logic       redirect;
	addr_t      redirect_addr;
	addr_t      ex_waddr;

	// stores take the port, fetch waits
	assign mem_grant = ~mem_wr;
	assign mem_rd = f_rd & mem_grant;
	assign mem_addr = mem_wr ? ex_waddr : f_addr;

	run_ctl run_ctl_i (
		.__clk  (__clk),
		.rst    (rst),
		.start  (start),
		.stop   (stop),
		.halt   (halt),
		.run    (run),
		.halted (halted)
	);

	fetch_stage fetch_i (
		.__clk         (__clk),
		.rst           (rst),
		.run           (run),
		.stall         (stall),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.mem_rdata     (mem_rdata),
		.mem_grant     (mem_grant),
		.mem_rd        (f_rd),
		.fetch_addr    (f_addr),
		.ir_valid      (ir_valid),
		.ir            (ir),
		.arg           (f_arg)
	);

	decode_stage decode_i (
		.__clk     (__clk),
		.rst       (rst),
		.ir_valid  (ir_valid),
		.ir        (ir),
		.arg       (f_arg),
		.busy      (busy),
		.stall     (stall),
		.d_valid   (d_valid),
		.uop       (uop),
		.ra        (ra),
		.rc        (rc),
		.shift_cnt (shift_cnt),
		.d_arg     (d_arg)
	);

	exec_stage exec_i (
		.__clk         (__clk),
		.rst           (rst),
		.d_valid       (d_valid),
		.uop           (uop),
		.ra            (ra),
		.rc            (rc),
		.shift_cnt     (shift_cnt),
		.d_arg         (d_arg),
		.busy          (busy),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.halt          (halt),
		.mem_wr        (mem_wr),
		.mem_waddr     (ex_waddr),
		.mem_wdata     (mem_wdata)
	);

endmodule

`default_nettype wire

// ==== hw/ctl_pkg.sv ====
`default_nettype none

package ctl_pkg;

	// run control, WAIT plays the part of the halt flip-flop
	typedef enum logic [1:0] {
		RS_IDLE,
		RS_RUN,
		RS_WAIT
	} run_state_t;

	// one microoperation per decoded instruction
	typedef enum logic [2:0] {
		UOP_NONE,
		UOP_W_R,
		UOP_ALU,
		UOP_SHIFT,
		UOP_SKIP,
		UOP_W_IC,
		UOP_STORE,
		UOP_HALT
	} uop_t;

	// alu function, carried in the low bits of the argument for UOP_ALU
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_fn_t;

endpackage

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                __clk,
	input  logic                rst,
	input  logic                ir_valid,
	input  isa_pkg::word_t      ir,
	input  isa_pkg::word_t      arg,
	input  logic                busy,
	output logic                stall,
	output logic                d_valid,
	output ctl_pkg::uop_t       uop,
	output isa_pkg::reg_idx_t   ra,
	output isa_pkg::reg_idx_t   rc,
	output logic [3:0]          shift_cnt,
	output isa_pkg::word_t      d_arg
);

	import isa_pkg::*;
	import ctl_pkg::*;

	opcode_t op;
	uop_t    uop_d;
	alu_fn_t fn_d;

	assign op = op_of(ir);

	// opcode to microoperation strobe
	always_comb begin
		uop_d = UOP_NONE;
		fn_d = ALU_ADD;
		case (op)
			OP_LWI: uop_d = UOP_W_R;
			OP_ADD: uop_d = UOP_ALU;
			OP_SUB: begin
				uop_d = UOP_ALU;
				fn_d = ALU_SUB;
			end
			OP_AND: begin
				uop_d = UOP_ALU;
				fn_d = ALU_AND;
			end
			OP_OR: begin
				uop_d = UOP_ALU;
				fn_d = ALU_OR;
			end
			OP_XOR: begin
				uop_d = UOP_ALU;
				fn_d = ALU_XOR;
			end
			OP_SHL: uop_d = UOP_SHIFT;
			OP_SZ: uop_d = UOP_SKIP;
			OP_UJ: uop_d = UOP_W_IC;
			OP_ST: uop_d = UOP_STORE;
			OP_HLT: uop_d = UOP_HALT;
			default: uop_d = UOP_NONE;
		endcase
	end

	// output held while execute steps a shift
	assign stall = busy;

	always_ff @(posedge __clk) begin
		if (rst) begin
			d_valid <= 1'b0;
		end else if (!busy) begin
			d_valid <= ir_valid;
		end
	end

	always_ff @(posedge __clk) begin
		if (!busy) begin
			uop <= uop_d;
			ra <= ra_of(ir);
			rc <= rc_of(ir);
			shift_cnt <= cnt_of(ir);
			// alu ops need no argument, the slot carries the function
			d_arg <= (uop_d == UOP_ALU) ? word_t'(fn_d) : arg;
		end
	end

endmodule

`default_nettype wire

// ==== hw/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module exec_stage (
	input  logic                __clk,
	input  logic                rst,
	input  logic                d_valid,
	input  ctl_pkg::uop_t       uop,
	input  isa_pkg::reg_idx_t   ra,
	input  isa_pkg::reg_idx_t   rc,
	input  logic [3:0]          shift_cnt,
	input  isa_pkg::word_t      d_arg,
	output logic                busy,
	output logic                redirect,
	output isa_pkg::addr_t      redirect_addr,
	output logic                halt,
	output logic                mem_wr,
	output isa_pkg::addr_t      mem_waddr,
	output isa_pkg::word_t      mem_wdata
);

	import isa_pkg::*;
	import ctl_pkg::*;

	word_t    regs [`CPU_NREG];
	logic     stepping;
	logic     squash;
	logic [3:0] step_cnt;
	reg_idx_t step_ra;

	logic     act;
	word_t    a_val;
	word_t    c_val;
	word_t    alu_res;
	logic     skip_take;

	// the instruction right behind a redirect is on the wrong path
	assign act = d_valid & ~stepping & ~squash;
	assign busy = stepping;

	assign a_val = regs[ra];
	assign c_val = regs[rc];

	always_comb begin
		case (alu_fn_t'(d_arg[2:0]))
			ALU_ADD: alu_res = a_val + c_val;
			ALU_SUB: alu_res = a_val - c_val;
			ALU_AND: alu_res = a_val & c_val;
			ALU_OR: alu_res = a_val | c_val;
			ALU_XOR: alu_res = a_val ^ c_val;
			default: alu_res = a_val;
		endcase
	end

	assign skip_take = act & (uop == UOP_SKIP) & (a_val == '0);

	// HLT also redirects, so a restart refetches from the word after it
	assign redirect = skip_take | (act & ((uop == UOP_W_IC) | (uop == UOP_HALT)));
	assign redirect_addr = d_arg[`CPU_ADDR_W-1:0];
	assign halt = act & (uop == UOP_HALT);

	assign mem_wr = act & (uop == UOP_STORE);
	assign mem_waddr = d_arg[`CPU_ADDR_W-1:0];
	assign mem_wdata = a_val;

	always_ff @(posedge __clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREG; i++) begin
				regs[i] <= '0;
			end
			stepping <= 1'b0;
			step_cnt <= '0;
			squash <= 1'b0;
		end else begin
			squash <= redirect;
			if (stepping) begin
				// one bit per step
				regs[step_ra] <= regs[step_ra] << 1;
				step_cnt <= step_cnt - 4'd1;
				if (step_cnt == 4'd1) begin
					stepping <= 1'b0;
				end
			end else if (act) begin
				case (uop)
					UOP_W_R: regs[ra] <= d_arg;
					UOP_ALU: regs[ra] <= alu_res;
					UOP_SHIFT: begin
						step_cnt <= shift_cnt;
						stepping <= (shift_cnt != 4'd0);
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (act && uop == UOP_SHIFT) begin
			step_ra <= ra;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic           __clk,
	input  logic           rst,
	input  logic           run,
	input  logic           stall,
	input  logic           redirect,
	input  isa_pkg::addr_t redirect_addr,
	input  isa_pkg::word_t mem_rdata,
	input  logic           mem_grant,
	output logic           mem_rd,
	output isa_pkg::addr_t fetch_addr,
	output logic           ir_valid,
	output isa_pkg::word_t ir,
	output isa_pkg::word_t arg
);

	import isa_pkg::*;

	// instruction word, argument word, or a look at the next word for SZ
	typedef enum logic [1:0] {
		RK_INSN,
		RK_ARG,
		RK_PEEK
	} rd_kind_t;

	addr_t    ic;
	rd_kind_t seq;
	logic     rd_pend;
	rd_kind_t rd_kind;
	word_t    asm_ir;
	logic     pf_valid;
	word_t    pf_ir;
	word_t    pf_arg;

	opcode_t  rd_op;
	rd_kind_t next_kind;
	logic     done;
	word_t    done_ir;
	word_t    done_arg;
	logic     ir_free;
	logic     pf_fill;
	logic     issue;

	assign rd_op = op_of(mem_rdata);

	// what the returning word completes, and what to read next
	always_comb begin
		next_kind = seq;
		done = 1'b0;
		done_ir = mem_rdata;
		// short forms carry the address after them
		done_arg = word_t'(ic);
		if (rd_pend) begin
			case (rd_kind)
				RK_INSN: begin
					if (is_long(rd_op)) begin
						next_kind = RK_ARG;
					end else if (rd_op == OP_SZ) begin
						next_kind = RK_PEEK;
					end else begin
						next_kind = RK_INSN;
						done = 1'b1;
					end
				end
				RK_ARG: begin
					next_kind = RK_INSN;
					done = 1'b1;
					done_ir = asm_ir;
					done_arg = mem_rdata;
				end
				default: begin
					// skip target depends on the length of the word looked at
					next_kind = RK_INSN;
					done = 1'b1;
					done_ir = asm_ir;
					done_arg = word_t'(ic + (is_long(rd_op) ? addr_t'(2) : addr_t'(1)));
				end
			endcase
		end
	end

	assign ir_free = ~ir_valid | ~stall;
	assign pf_fill = done & ~ir_free;

	// read only when a completed instruction will have somewhere to land
	assign mem_rd = run & ~redirect & ~pf_valid & ~pf_fill;
	assign issue = mem_rd & mem_grant;
	assign fetch_addr = ic;

	always_ff @(posedge __clk) begin
		if (rst) begin
			ic <= '0;
			seq <= RK_INSN;
			rd_pend <= 1'b0;
			rd_kind <= RK_INSN;
			ir_valid <= 1'b0;
			pf_valid <= 1'b0;
		end else if (redirect) begin
			// drop prefetch and the read in flight
			ic <= redirect_addr;
			seq <= RK_INSN;
			rd_pend <= 1'b0;
			ir_valid <= 1'b0;
			pf_valid <= 1'b0;
		end else begin
			rd_pend <= issue;
			seq <= next_kind;
			if (issue) begin
				rd_kind <= next_kind;
				if (next_kind != RK_PEEK) begin
					ic <= ic + addr_t'(1);
				end
			end
			if (ir_free) begin
				ir_valid <= pf_valid | done;
				pf_valid <= pf_valid & done;
			end else if (done) begin
				pf_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (rd_pend && rd_kind == RK_INSN) begin
			asm_ir <= mem_rdata;
		end
		if (ir_free) begin
			ir <= pf_valid ? pf_ir : done_ir;
			arg <= pf_valid ? pf_arg : done_arg;
		end
		if (done && (pf_valid || !ir_free)) begin
			pf_ir <= done_ir;
			pf_arg <= done_arg;
		end
	end

endmodule

`default_nettype wire

// ==== hw/isa_pkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package isa_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [$clog2(`CPU_NREG)-1:0] reg_idx_t;

	// opcode in bits 15..12, codes 12..15 unused
	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_LWI = 4'h1,
		OP_ADD = 4'h2,
		OP_SUB = 4'h3,
		OP_AND = 4'h4,
		OP_OR  = 4'h5,
		OP_XOR = 4'h6,
		OP_SHL = 4'h7,
		OP_SZ  = 4'h8,
		OP_UJ  = 4'h9,
		OP_ST  = 4'ha,
		OP_HLT = 4'hb
	} opcode_t;

	// instruction fields
	//   15..12 opcode, 11..9 ra, 8..6 rc, 3..0 shift count
	// long forms are followed by one argument word
	function automatic opcode_t op_of(word_t w);
		return opcode_t'(w[15:12]);
	endfunction

	function automatic reg_idx_t ra_of(word_t w);
		return w[11:9];
	endfunction

	function automatic reg_idx_t rc_of(word_t w);
		return w[8:6];
	endfunction

	function automatic logic [3:0] cnt_of(word_t w);
		return w[3:0];
	endfunction

	function automatic logic is_long(opcode_t op);
		return (op == OP_LWI) || (op == OP_UJ) || (op == OP_ST);
	endfunction

endpackage

`default_nettype wire

// ==== hw/run_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module run_ctl (
	input  logic __clk,
	input  logic rst,
	input  logic start,
	input  logic stop,
	input  logic halt,
	output logic run,
	output logic halted
);

	import ctl_pkg::*;

	run_state_t state;
	run_state_t state_nx;

	// halt wins over stop, stop over start
	always_comb begin
		state_nx = state;
		if (halt) begin
			state_nx = RS_WAIT;
		end else if (stop) begin
			state_nx = RS_IDLE;
		end else if (start) begin
			state_nx = RS_RUN;
		end
	end

	always_ff @(posedge __clk) begin
		if (rst) begin
			state <= RS_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	// levels straight off the state flops
	assign run = (state == RS_RUN);
	assign halted = (state == RS_WAIT);

endmodule

`default_nettype wire

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu;

	import isa_pkg::*;

	localparam int SEED = 81991;
	localparam int N_PROG = 24;
	localparam int PROG_LEN = 40;
	localparam int CYCLE_LIMIT = N_PROG * PROG_LEN * 20;
	localparam int MEM_WORDS = 1 << `CPU_ADDR_W;

	logic  __clk;
	logic  rst;
	logic  start;
	logic  stop;
	word_t mem_rdata;
	logic  run;
	logic  halted;
	addr_t mem_addr;
	logic  mem_rd;
	logic  mem_wr;
	word_t mem_wdata;

	word_t mem [MEM_WORDS];
	logic  rd_seen;
	addr_t rd_addr_seen;
	int    final_addr;

	// expected stores, and how many precede each reached HLT
	addr_t exp_addr [$];
	word_t exp_data [$];
	int    halt_marks [$];
	int    store_idx;
	int    seg_limit;
	int    errors;
	int    n_stores;
	int    n_run_checks;
	int    cycles;

	cpu_top dut_i (
		.__clk     (__clk),
		.rst       (rst),
		.start     (start),
		.stop      (stop),
		.mem_rdata (mem_rdata),
		.run       (run),
		.halted    (halted),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_wdata (mem_wdata)
	);

	always #10 __clk = ~__clk;

	task automatic check_store(input isa_pkg::addr_t a, input isa_pkg::word_t d);
		n_stores++;
		if (store_idx >= seg_limit) begin
			$display("unexpected store at %0t: %h written to %h, no store due here", $time, d, a);
			errors++;
		end else begin
			if (a !== exp_addr[store_idx] || d !== exp_data[store_idx]) begin
				$display("ERROR %0t: store %0d wrote %h to %h, expected %h to %h", $time,
					store_idx, d, a, exp_data[store_idx], exp_addr[store_idx]);
				errors++;
			end
			store_idx++;
		end
	endtask

	task automatic check_run(input logic exp_run, input logic exp_halted);
		n_run_checks++;
		if (run !== exp_run || halted !== exp_halted) begin
			$display("ERROR %0t: run=%b halted=%b, expected run=%b halted=%b", $time,
				run, halted, exp_run, exp_halted);
			errors++;
		end
	endtask

	task automatic check_port_idle(input logic exp_rd, input logic exp_wr);
		if (mem_rd !== exp_rd || mem_wr !== exp_wr) begin
			$display("ERROR %0t: mem_rd=%b mem_wr=%b, expected mem_rd=%b mem_wr=%b", $time,
				mem_rd, mem_wr, exp_rd, exp_wr);
			errors++;
		end
	endtask

	// memory port sampled mid-cycle where the outputs have settled
	always @(negedge __clk) begin
		rd_seen = (mem_rd === 1'b1);
		rd_addr_seen = mem_addr;
		if (mem_wr === 1'b1) begin
			check_store(mem_addr, mem_wdata);
			mem[mem_addr] = mem_wdata;
		end
	end

	// read data one cycle after the request
	always @(posedge __clk) begin
		#1;
		if (rd_seen) begin
			mem_rdata = mem[rd_addr_seen];
		end
	end

	always @(posedge __clk) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
			$display("counts: %0d stores, %0d run checks, %0d errors", n_stores, n_run_checks,
				errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic gen_program(input int n_mid);
		int         starts [PROG_LEN];
		bit         halt_at [PROG_LEN];
		int         jumps [$];
		int         pc;
		int         pick;
		int         span;
		int         t;
		logic [3:0] op;
		logic [5:0] low;
		reg_idx_t   ra;
		reg_idx_t   rc;
		// unused words decode as no-ops tagged with their address
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = word_t'({4'hf, addr_t'(a)});
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			halt_at[i] = 1'b0;
		end
		// mid halts kept clear of the start so an early stop never meets one
		for (int h = 0; h < n_mid; h++) begin
			halt_at[$urandom_range(10, PROG_LEN - 3)] = 1'b1;
		end
		halt_at[PROG_LEN - 1] = 1'b1;
		pc = 0;
		for (int i = 0; i < PROG_LEN; i++) begin
			starts[i] = pc;
			ra = reg_idx_t'($urandom);
			rc = reg_idx_t'($urandom);
			low = 6'($urandom);
			pick = halt_at[i] ? 16 : int'($urandom % 16);
			case (pick)
				0, 1, 2: op = OP_LWI;
				3, 4, 5, 6: op = 4'(int'(OP_ADD) + int'($urandom % 5));
				7, 8: op = OP_SHL;
				// a skip may not jump over the final HLT
				9, 10: op = (i == PROG_LEN - 2) ? OP_NOP : OP_SZ;
				11: op = OP_UJ;
				12, 13, 14: op = OP_ST;
				15: op = OP_NOP;
				default: op = OP_HLT;
			endcase
			mem[pc] = {op, ra, rc, low};
			if (op == OP_LWI) begin
				mem[pc + 1] = ($urandom_range(0, 2) == 0) ? '0 : word_t'($urandom);
			end else if (op == OP_ST) begin
				mem[pc + 1] = word_t'(16'h0f00 + 16'($urandom % 256));
			end else if (op == OP_UJ) begin
				jumps.push_back(i);
			end
			pc += (op == OP_LWI || op == OP_ST || op == OP_UJ) ? 2 : 1;
		end
		// forward jumps onto instruction boundaries only
		foreach (jumps[j]) begin
			span = PROG_LEN - 1 - jumps[j];
			if (span > 4) begin
				span = 4;
			end
			t = jumps[j] + 1 + int'($urandom % span);
			mem[starts[jumps[j]] + 1] = word_t'(starts[t]);
		end
		final_addr = starts[PROG_LEN - 1];
	endtask

	task automatic run_model();
		word_t      r [`CPU_NREG];
		int         pc;
		int         steps;
		word_t      w;
		logic [3:0] nxt;
		reg_idx_t   ra;
		reg_idx_t   rc;
		logic       finished;
		exp_addr.delete();
		exp_data.delete();
		halt_marks.delete();
		for (int i = 0; i < `CPU_NREG; i++) begin
			r[i] = '0;
		end
		pc = 0;
		steps = 0;
		finished = 1'b0;
		while (!finished && steps < MEM_WORDS) begin
			w = mem[pc];
			ra = w[11:9];
			rc = w[8:6];
			steps++;
			case (w[15:12])
				OP_LWI: begin
					r[ra] = mem[pc + 1];
					pc += 2;
				end
				OP_ADD: begin
					r[ra] = r[ra] + r[rc];
					pc += 1;
				end
				OP_SUB: begin
					r[ra] = r[ra] - r[rc];
					pc += 1;
				end
				OP_AND: begin
					r[ra] = r[ra] & r[rc];
					pc += 1;
				end
				OP_OR: begin
					r[ra] = r[ra] | r[rc];
					pc += 1;
				end
				OP_XOR: begin
					r[ra] = r[ra] ^ r[rc];
					pc += 1;
				end
				OP_SHL: begin
					r[ra] = r[ra] << w[3:0];
					pc += 1;
				end
				OP_SZ: begin
					nxt = mem[pc + 1][15:12];
					if (r[ra] != '0) begin
						pc += 1;
					end else if (nxt == OP_LWI || nxt == OP_UJ || nxt == OP_ST) begin
						pc += 3;
					end else begin
						pc += 2;
					end
				end
				OP_UJ: pc = int'(mem[pc + 1][11:0]);
				OP_ST: begin
					exp_addr.push_back(mem[pc + 1][11:0]);
					exp_data.push_back(r[ra]);
					pc += 2;
				end
				OP_HLT: begin
					halt_marks.push_back(exp_addr.size());
					finished = (pc == final_addr);
					pc += 1;
				end
				default: pc += 1;
			endcase
		end
	endtask

	task automatic apply_reset();
		@(posedge __clk);
		#1;
		rst = 1'b1;
		repeat (5) @(posedge __clk);
		#1;
		rst = 1'b0;
		@(negedge __clk);
		check_run(1'b0, 1'b0);
		check_port_idle(1'b0, 1'b0);
	endtask

	task automatic pulse_start();
		@(posedge __clk);
		#1;
		start = 1'b1;
		@(posedge __clk);
		#1;
		start = 1'b0;
		@(negedge __clk);
		check_run(1'b1, 1'b0);
	endtask

	task automatic stop_and_resume();
		repeat ($urandom_range(1, 4)) @(posedge __clk);
		#1;
		stop = 1'b1;
		@(posedge __clk);
		#1;
		stop = 1'b0;
		@(negedge __clk);
		check_run(1'b0, 1'b0);
		// pipeline drains with fetch idle
		repeat (8) @(negedge __clk);
		check_run(1'b0, 1'b0);
		pulse_start();
	endtask

	task automatic wait_for_halt();
		// either level moving ends the wait, both must then agree with a halt
		do begin
			@(negedge __clk);
		end while (run === 1'b1 && halted !== 1'b1);
		check_run(1'b0, 1'b1);
		if (store_idx < seg_limit) begin
			$display("missing stores at %0t: only %0d of %0d stores seen before the halt",
				$time, store_idx, seg_limit);
			errors++;
		end
	endtask

	initial begin
		int n_mid;
		__clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		stop = 1'b0;
		mem_rdata = '0;
		rd_seen = 1'b0;
		rd_addr_seen = '0;
		store_idx = 0;
		seg_limit = 0;
		errors = 0;
		n_stores = 0;
		n_run_checks = 0;
		cycles = 0;
		void'($urandom(SEED));
		for (int p = 0; p < N_PROG; p++) begin
			n_mid = $urandom_range(0, 2);
			gen_program(n_mid);
			run_model();
			store_idx = 0;
			seg_limit = 0;
			// code restarts at 0 with cleared registers
			apply_reset();
			for (int s = 0; s < halt_marks.size(); s++) begin
				seg_limit = halt_marks[s];
				pulse_start();
				if (s == 0 && p % 3 == 1) begin
					stop_and_resume();
				end
				wait_for_halt();
				repeat (2) @(negedge __clk);
			end
		end
		$display("counts: %0d programs, %0d stores, %0d run checks, %0d errors", N_PROG,
			n_stores, n_run_checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
